// File: hdl/fb_config.svh
// Matrix geometry and command opcode values for the framebuffer front end.
`ifndef FB_CONFIG_SVH
`define FB_CONFIG_SVH

// ------------------------------------------------------------
// Matrix geometry
// ------------------------------------------------------------
// Number of matrix rows.
`define FB_ROWS 16
// Column address width, 512 columns over two column bytes.
`define FB_COL_ADDR_BITS 9
// Colour bytes stored per pixel.
`define FB_BYTES_PER_PIXEL 3

// ------------------------------------------------------------
// Command opcodes
// ------------------------------------------------------------
`define CMD_NOP 8'h00
`define CMD_WRITE_PIXEL 8'h01
`define CMD_READ_PIXEL 8'h02

`endif

// File: hdl/fb_pkg.sv
// Framebuffer address types, RAM write-port struct and command opcode enum.
`include "fb_config.svh"

package fb_pkg;

    // Whole bytes needed to carry a field of the given width.
    function automatic int unsigned num_bytes_to_contain(input int unsigned bits);
        return (bits + 7) / 8;
    endfunction

    // ------------------------------------------------------------
    // Address types
    // ------------------------------------------------------------
    typedef logic [$clog2(`FB_ROWS)-1:0]            row_addr_t;
    typedef logic [`FB_COL_ADDR_BITS-1:0]           col_addr_t;
    typedef logic [$clog2(`FB_BYTES_PER_PIXEL)-1:0] color_index_t;

    typedef struct packed {
        row_addr_t    row;
        col_addr_t    col;
        color_index_t pixel;   // Byte within the pixel.
    } fb_addr_t;

    localparam int unsigned COL_BYTES = num_bytes_to_contain(`FB_COL_ADDR_BITS);
    localparam int unsigned COL_IDX_BITS = (COL_BYTES > 1) ? $clog2(COL_BYTES) : 1;

    typedef logic [COL_BYTES*8-1:0]  col_field_t;         // Column bytes, low byte first.
    typedef logic [COL_IDX_BITS-1:0] col_field_index_t;

    // Write port into the framebuffer RAM.
    typedef struct packed {
        fb_addr_t   addr;
        logic [7:0] data;
        logic       write_enable;
        logic       access_toggle;   // Flips once per byte written.
    } fb_wr_t;

    typedef enum logic [7:0] {
        OP_NOP         = `CMD_NOP,
        OP_WRITE_PIXEL = `CMD_WRITE_PIXEL,
        OP_READ_PIXEL  = `CMD_READ_PIXEL
    } cmd_opcode_t;

endpackage

// File: hdl/cmd_dispatch.sv
// Command dispatcher: decodes opcodes and steers the following bytes to a handler.
`timescale 1ns/1ps

module cmd_dispatch
    import fb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic       wr_done,
    input  logic       rd_done,
    output logic       wr_enable,
    output logic       rd_enable,
    output logic       busy
);

    typedef enum logic {
        ST_IDLE,
        ST_ACTIVE
    } disp_state_t;

    disp_state_t state;
    cmd_opcode_t opcode;
    logic        handler_done;

    // Only the done of the handler that owns the command counts.
    assign handler_done = ((opcode == OP_WRITE_PIXEL) && wr_done) ||
                          ((opcode == OP_READ_PIXEL) && rd_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= ST_IDLE;
            opcode <= OP_NOP;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (rx_valid) begin
                        case (cmd_opcode_t'(rx_data))
                            OP_WRITE_PIXEL: begin
                                opcode <= OP_WRITE_PIXEL;
                                state  <= ST_ACTIVE;
                            end
                            OP_READ_PIXEL: begin
                                opcode <= OP_READ_PIXEL;
                                state  <= ST_ACTIVE;
                            end
                            default: opcode <= OP_NOP;   // NOP and unknown bytes dropped.
                        endcase
                    end
                end
                ST_ACTIVE: begin
                    if (handler_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Byte steering
    // ------------------------------------------------------------
    assign wr_enable = rx_valid && (state == ST_ACTIVE) && (opcode == OP_WRITE_PIXEL);
    assign rd_enable = rx_valid && (state == ST_ACTIVE) && (opcode == OP_READ_PIXEL);
    assign busy      = (state == ST_ACTIVE);

    // Both handlers must never take the same byte.
    a_one_handler: assert property (
        @(posedge clk) disable iff (reset)
        !(wr_enable && rd_enable)
    );

endmodule

// File: hdl/cmd_write_pixel.sv
// Write-pixel handler: gathers row, column and pixel bytes and writes them to the RAM.
`timescale 1ns/1ps
`include "fb_config.svh"

module cmd_write_pixel
    import fb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       enable,
    output fb_wr_t     wr,
    output logic       done
);

    localparam int unsigned NUM_COL_BYTES = num_bytes_to_contain($bits(col_addr_t));

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_COL_CAPTURE,
        ST_PIXEL_BYTES,
        ST_DONE
    } wr_state_t;

    wr_state_t        state;
    col_field_t       col_bits;
    col_field_t       col_shifted;
    col_field_index_t col_cnt;
    color_index_t     pixel_idx;

    // Column bytes arrive low byte first and shift in from the top.
    assign col_shifted = {data_in, col_bits[$bits(col_field_t)-1:8]};

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= ST_ROW_CAPTURE;
            col_bits         <= '0;
            col_cnt          <= '0;
            pixel_idx        <= '0;
            wr.addr          <= '0;
            wr.data          <= 8'h00;
            wr.write_enable  <= 1'b0;
            wr.access_toggle <= 1'b0;
            done             <= 1'b0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        wr.addr.row <= row_addr_t'(data_in);   // Upper bits wrap.
                        col_cnt     <= col_field_index_t'(NUM_COL_BYTES - 1);
                        state       <= ST_COL_CAPTURE;
                    end
                end

                ST_COL_CAPTURE: begin
                    if (enable) begin
                        col_bits <= col_shifted;
                        if (col_cnt == '0) begin
                            wr.addr.col <= col_addr_t'(col_shifted);
                            pixel_idx   <= color_index_t'(`FB_BYTES_PER_PIXEL - 1);
                            state       <= ST_PIXEL_BYTES;
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                end

                ST_PIXEL_BYTES: begin
                    if (enable) begin
                        // One RAM write per pixel byte.
                        wr.data          <= data_in;
                        wr.addr.pixel    <= pixel_idx;
                        wr.write_enable  <= 1'b1;
                        wr.access_toggle <= ~wr.access_toggle;
                        if (pixel_idx == '0) begin
                            done  <= 1'b1;
                            state <= ST_DONE;
                        end else begin
                            pixel_idx <= pixel_idx - 1'b1;
                        end
                    end
                end

                ST_DONE: begin
                    // Last write is taken by the RAM during this cycle.
                    done            <= 1'b0;
                    wr.write_enable <= 1'b0;
                    wr.addr         <= '0;
                    col_bits        <= '0;
                    state           <= ST_ROW_CAPTURE;
                end

                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

    // A toggle with no enable would be silently dropped by the RAM.
    a_toggle_with_enable: assert property (
        @(posedge clk) disable iff (reset)
        $changed(wr.access_toggle) |-> wr.write_enable
    );

endmodule

// File: hdl/cmd_read_pixel.sv
// Read-pixel handler: gathers row and column, reads the pixel bytes and sends them out.
`timescale 1ns/1ps
`include "fb_config.svh"

module cmd_read_pixel
    import fb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] data_in,
    input  logic       enable,
    input  logic [7:0] rd_data,
    output fb_addr_t   rd_addr,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic       done
);

    localparam int unsigned NUM_COL_BYTES = num_bytes_to_contain($bits(col_addr_t));

    typedef enum logic [1:0] {
        ST_ROW_CAPTURE,
        ST_COL_CAPTURE,
        ST_READ_BYTES
    } rd_state_t;

    rd_state_t        state;
    col_field_t       col_bits;
    col_field_t       col_shifted;
    col_field_index_t col_cnt;
    logic             issuing;
    logic             rd_valid_q;
    logic             rd_last_q;

    assign col_shifted = {data_in, col_bits[$bits(col_field_t)-1:8]};
    assign issuing     = (state == ST_READ_BYTES);

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_ROW_CAPTURE;
            col_bits <= '0;
            col_cnt  <= '0;
            rd_addr  <= '0;
        end else begin
            case (state)
                ST_ROW_CAPTURE: begin
                    if (enable) begin
                        rd_addr.row <= row_addr_t'(data_in);
                        col_cnt     <= col_field_index_t'(NUM_COL_BYTES - 1);
                        state       <= ST_COL_CAPTURE;
                    end
                end

                ST_COL_CAPTURE: begin
                    if (enable) begin
                        col_bits <= col_shifted;
                        if (col_cnt == '0) begin
                            rd_addr.col   <= col_addr_t'(col_shifted);
                            rd_addr.pixel <= color_index_t'(`FB_BYTES_PER_PIXEL - 1);
                            state         <= ST_READ_BYTES;
                        end else begin
                            col_cnt <= col_cnt - 1'b1;
                        end
                    end
                end

                ST_READ_BYTES: begin
                    // One address per cycle, highest pixel byte first.
                    if (rd_addr.pixel == '0) begin
                        state <= ST_ROW_CAPTURE;
                    end else begin
                        rd_addr.pixel <= rd_addr.pixel - 1'b1;
                    end
                end

                default: state <= ST_ROW_CAPTURE;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Read-back pipeline
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
            rd_last_q  <= 1'b0;
            tx_valid   <= 1'b0;
            tx_data    <= 8'h00;
            done       <= 1'b0;
        end else begin
            rd_valid_q <= issuing;   // Lines up with rd_data.
            rd_last_q  <= issuing && (rd_addr.pixel == '0);
            tx_valid   <= rd_valid_q;
            done       <= rd_last_q;
            if (rd_valid_q) begin
                tx_data <= rd_data;
            end
        end
    end

    // Command bytes must not arrive while the read burst runs.
    a_no_enable_in_read: assert property (
        @(posedge clk) disable iff (reset)
        issuing |-> !enable
    );

endmodule

// File: hdl/framebuffer_ram.sv
// Framebuffer byte RAM with a toggle-triggered write port and a registered read port.
`timescale 1ns/1ps
`include "fb_config.svh"

module framebuffer_ram
    import fb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  fb_wr_t     wr,
    input  fb_addr_t   rd_addr,
    output logic [7:0] rd_data
);

    localparam int unsigned NUM_COLS = 1 << `FB_COL_ADDR_BITS;
    localparam int unsigned DEPTH    = `FB_ROWS * NUM_COLS * `FB_BYTES_PER_PIXEL;
    localparam int unsigned IDX_BITS = $clog2(DEPTH);

    typedef logic [IDX_BITS-1:0] mem_idx_t;

    logic [7:0] mem [DEPTH];
    logic       prev_toggle;
    logic       wr_strobe;
    mem_idx_t   wr_idx;
    mem_idx_t   rd_idx;

    // Row-major pixels, each holding its colour bytes back to back.
    function automatic mem_idx_t byte_index(input fb_addr_t a);
        return mem_idx_t'((int'(a.row) * NUM_COLS + int'(a.col)) * `FB_BYTES_PER_PIXEL
                          + int'(a.pixel));
    endfunction

    assign wr_idx    = byte_index(wr.addr);
    assign rd_idx    = byte_index(rd_addr);
    assign wr_strobe = wr.write_enable && (wr.access_toggle != prev_toggle);

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = 8'h00;   // Blank frame at power-up.
        end
    end

    // ------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            prev_toggle <= 1'b0;
        end else begin
            prev_toggle <= wr.access_toggle;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            mem[wr_idx] <= wr.data;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_idx];   // One cycle latency.
    end

    // The writer's pixel counter must stay inside the pixel.
    a_pixel_in_range: assert property (
        @(posedge clk) disable iff (reset)
        wr_strobe |-> (int'(wr.addr.pixel) < `FB_BYTES_PER_PIXEL)
    );

endmodule

// File: hdl/fb_cmd_top.sv
// Top level of the command front end: dispatcher, both handlers and the framebuffer RAM.
`timescale 1ns/1ps

module fb_cmd_top
    import fb_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    output logic       busy
);

    logic       wr_enable;
    logic       rd_enable;
    logic       wr_done;
    logic       rd_done;
    fb_wr_t     fb_wr;
    fb_addr_t   fb_rd_addr;
    logic [7:0] fb_rd_data;

    // ------------------------------------------------------------
    // Input side
    // ------------------------------------------------------------
    cmd_dispatch u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .rx_data   (rx_data),
        .rx_valid  (rx_valid),
        .wr_done   (wr_done),
        .rd_done   (rd_done),
        .wr_enable (wr_enable),
        .rd_enable (rd_enable),
        .busy      (busy)
    );

    // ------------------------------------------------------------
    // Command handlers
    // ------------------------------------------------------------
    cmd_write_pixel u_write_pixel (
        .clk     (clk),
        .reset   (reset),
        .data_in (rx_data),
        .enable  (wr_enable),
        .wr      (fb_wr),
        .done    (wr_done)
    );

    cmd_read_pixel u_read_pixel (
        .clk      (clk),
        .reset    (reset),
        .data_in  (rx_data),
        .enable   (rd_enable),
        .rd_data  (fb_rd_data),
        .rd_addr  (fb_rd_addr),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .done     (rd_done)
    );

    // Pixel storage.
    framebuffer_ram u_ram (
        .clk     (clk),
        .reset   (reset),
        .wr      (fb_wr),
        .rd_addr (fb_rd_addr),
        .rd_data (fb_rd_data)
    );

endmodule

// File: verif/fb_cmd_checker.sv
// Scoreboard for the command front end: decodes rx bytes into a framebuffer model
// and compares every tx byte, busy and read completion against it.
`timescale 1ns/1ps
`include "fb_config.svh"

module fb_cmd_checker (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] rx_data,
    input  logic       rx_valid,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    input  logic       busy,
    input  logic       end_of_test,
    output int         reads_checked,
    output int         data_errors,
    output int         protocol_errors
);

    localparam int NUM_COLS   = 1 << `FB_COL_ADDR_BITS;
    localparam int BPP        = `FB_BYTES_PER_PIXEL;
    localparam int MODEL_SIZE = `FB_ROWS * NUM_COLS * BPP;
    localparam int COL_BYTES  = (`FB_COL_ADDR_BITS + 7) / 8;

    // Decoder phases of the reference model.
    localparam int DEC_OPCODE = 0;
    localparam int DEC_ROW    = 1;
    localparam int DEC_COL    = 2;
    localparam int DEC_PIXEL  = 3;

    logic [7:0] fb_model [MODEL_SIZE];
    logic [7:0] expected_q [$];
    int         dec_state;
    logic       is_write;
    int         row;
    int         col;
    int         col_acc;
    int         col_count;
    int         pix_idx;
    logic       seen_opcode;
    logic       busy_check_pending;
    logic       busy_expected;
    logic       end_seen;

    initial begin
        for (int i = 0; i < MODEL_SIZE; i++) begin
            fb_model[i] = 8'h00;   // Matches a blank RAM.
        end
    end

    function automatic int pixel_base(input int r, input int c);
        return (r * NUM_COLS + c) * BPP;
    endfunction

    task automatic protocol_error(input string what);
        protocol_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    task automatic check_busy(input logic expected);
        if (busy !== expected) begin
            protocol_errors++;
            $display("Fail busy at %0t: expected 0x%0h, actual 0x%0h", $time, expected, busy);
        end
    endtask

    task automatic check_tx_byte();
        logic [7:0] exp_byte;
        if (expected_q.size() == 0) begin
            protocol_error("tx_valid pulsed with no read byte outstanding");
        end else begin
            exp_byte = expected_q.pop_front();
            if (tx_data !== exp_byte) begin
                data_errors++;
                $display("Fail tx_data at %0t: expected 0x%02h, actual 0x%02h",
                         $time, exp_byte, tx_data);
            end
            if (expected_q.size() == 0) begin
                reads_checked++;
            end
        end
    endtask

    task automatic decode_byte(input logic [7:0] b);
        case (dec_state)
            DEC_OPCODE: begin
                check_busy(1'b0);   // Previous command fully finished.
                if (expected_q.size() != 0) begin
                    protocol_error("opcode arrived before the previous read was sent");
                end
                seen_opcode        = 1'b1;
                busy_check_pending = 1'b1;
                busy_expected      = (b == `CMD_WRITE_PIXEL) || (b == `CMD_READ_PIXEL);
                if (busy_expected) begin
                    is_write  = (b == `CMD_WRITE_PIXEL);
                    dec_state = DEC_ROW;
                end
            end
            DEC_ROW: begin
                row       = int'(b) & (`FB_ROWS - 1);   // Upper bits ignored.
                col_acc   = 0;
                col_count = 0;
                dec_state = DEC_COL;
            end
            DEC_COL: begin
                col_acc = col_acc | (int'(b) << (8 * col_count));   // Low byte first.
                col_count++;
                if (col_count == COL_BYTES) begin
                    col     = col_acc & (NUM_COLS - 1);
                    pix_idx = BPP - 1;
                    if (is_write) begin
                        dec_state = DEC_PIXEL;
                    end else begin
                        for (int p = BPP - 1; p >= 0; p--) begin
                            expected_q.push_back(fb_model[pixel_base(row, col) + p]);
                        end
                        dec_state = DEC_OPCODE;
                    end
                end
            end
            DEC_PIXEL: begin
                fb_model[pixel_base(row, col) + pix_idx] = b;
                if (pix_idx == 0) begin
                    dec_state = DEC_OPCODE;
                end else begin
                    pix_idx--;
                end
            end
            default: dec_state = DEC_OPCODE;
        endcase
    endtask

    // ------------------------------------------------------------
    // Sampling at the falling edge, where all ports are settled
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            dec_state          = DEC_OPCODE;
            seen_opcode        = 1'b0;
            busy_check_pending = 1'b0;
            end_seen           = 1'b0;
            reads_checked      = 0;
            data_errors        = 0;
            protocol_errors    = 0;
            expected_q.delete();
        end else begin
            if (busy_check_pending) begin
                check_busy(busy_expected);   // One cycle after the opcode.
                busy_check_pending = 1'b0;
            end
            if (!seen_opcode && busy) begin
                protocol_error("busy high before any opcode arrived");
            end
            if (tx_valid) begin
                check_tx_byte();
            end
            if (rx_valid) begin
                decode_byte(rx_data);
            end
            if (end_of_test && !end_seen) begin
                end_seen = 1'b1;
                if (expected_q.size() != 0) begin
                    protocol_error("read bytes were still missing at the end of the run");
                end
                if (dec_state != DEC_OPCODE) begin
                    protocol_error("the run ended in the middle of a command");
                end
            end
        end
    end

endmodule

// File: verif/tb_fb_cmd.sv
// Testbench top: clock, reset, watchdog, random command stimulus, DUT and checker.
`timescale 1ns/1ps
`include "fb_config.svh"

module tb_fb_cmd;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int NUM_CMDS      = 300;
    localparam int MAX_GAP       = 4;      // Cycles per byte, two at least.
    localparam int NUM_COLS      = 1 << `FB_COL_ADDR_BITS;
    localparam int COL_BYTES     = (`FB_COL_ADDR_BITS + 7) / 8;
    localparam int MAX_CMD_BYTES = 2 + COL_BYTES + `FB_BYTES_PER_PIXEL;
    localparam int IDLE_TIMEOUT  = 50;
    localparam int POOL_SIZE     = 8;
    localparam int TIMEOUT_NS    = (NUM_CMDS + 4) * MAX_CMD_BYTES * MAX_GAP * CLK_PERIOD
                                   + 500 * CLK_PERIOD;

    logic       clk;
    logic       reset;
    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       busy;
    logic       end_of_test;
    int         reads_checked;
    int         data_errors;
    int         protocol_errors;
    int         stim_errors;
    int         pool_row [POOL_SIZE];
    int         pool_col [POOL_SIZE];

    fb_cmd_top u_dut (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .busy     (busy)
    );

    fb_cmd_checker u_checker (
        .clk             (clk),
        .reset           (reset),
        .rx_data         (rx_data),
        .rx_valid        (rx_valid),
        .tx_data         (tx_data),
        .tx_valid        (tx_valid),
        .busy            (busy),
        .end_of_test     (end_of_test),
        .reads_checked   (reads_checked),
        .data_errors     (data_errors),
        .protocol_errors (protocol_errors)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns, the run did not complete", TIMEOUT_NS);
        $display("TESTS FAILED");
        $finish;
    end

    // ------------------------------------------------------------
    // Byte driving
    // ------------------------------------------------------------
    task automatic send_byte(input logic [7:0] b);
        @(posedge clk);
        rx_data  <= b;
        rx_valid <= 1'b1;
        @(posedge clk);
        rx_valid <= 1'b0;
        repeat ($urandom_range(0, MAX_GAP - 2)) @(posedge clk);
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (busy && cycles < IDLE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (busy) begin
            stim_errors++;
            $display("Error at %0t: busy stayed high for %0d cycles", $time, IDLE_TIMEOUT);
        end
    endtask

    task automatic send_opcode(input logic [7:0] op);
        wait_idle();
        send_byte(op);
    endtask

    // Random upper bits on row and column bytes exercise the masking.
    task automatic send_address(input int idx);
        int row_byte;
        int col_word;
        row_byte = pool_row[idx] | (int'($urandom_range(0, 255)) & ~(`FB_ROWS - 1));
        col_word = pool_col[idx] | (int'($urandom()) & ~(NUM_COLS - 1));
        send_byte(8'(row_byte));
        for (int k = 0; k < COL_BYTES; k++) begin
            send_byte(8'(col_word >> (8 * k)));
        end
    endtask

    task automatic write_pixel(input int idx);
        send_opcode(`CMD_WRITE_PIXEL);
        send_address(idx);
        repeat (`FB_BYTES_PER_PIXEL) send_byte(8'($urandom()));
    endtask

    task automatic read_pixel(input int idx);
        send_opcode(`CMD_READ_PIXEL);
        send_address(idx);
    endtask

    initial begin
        int choice;
        int idx;
        void'($urandom(32'h2fa38929));
        reset       = 1'b1;
        rx_data     = 8'h00;
        rx_valid    = 1'b0;
        end_of_test = 1'b0;
        stim_errors = 0;
        // Pixels 0 and 1 differ only in column bit 8.
        pool_row[0] = $urandom_range(0, `FB_ROWS - 1);
        pool_col[0] = $urandom_range(0, 255);
        pool_row[1] = pool_row[0];
        pool_col[1] = pool_col[0] + 256;
        for (int i = 2; i < POOL_SIZE; i++) begin
            pool_row[i] = $urandom_range(0, `FB_ROWS - 1);
            pool_col[i] = $urandom_range(0, NUM_COLS - 1);
        end
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        repeat (5) @(posedge clk);

        read_pixel(0);   // Never written, reads back as zero.
        read_pixel(1);
        write_pixel(0);
        write_pixel(1);
        read_pixel(0);
        read_pixel(1);

        for (int n = 0; n < NUM_CMDS; n++) begin
            choice = $urandom_range(0, 9);
            idx    = $urandom_range(0, POOL_SIZE - 1);
            if (choice < 4) begin
                write_pixel(idx);
            end else if (choice < 7) begin
                read_pixel(idx);
            end else if (choice == 7) begin
                send_opcode(`CMD_NOP);
            end else begin
                send_opcode(8'($urandom_range(3, 255)));   // Unknown opcode.
            end
        end

        wait_idle();
        repeat (4) @(posedge clk);
        end_of_test <= 1'b1;
        repeat (3) @(negedge clk);
        $display("Summary: %0d reads checked, errors: %0d data, %0d protocol, %0d stimulus",
                 reads_checked, data_errors, protocol_errors, stim_errors);
        if (data_errors + protocol_errors + stim_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+hdl
hdl/fb_pkg.sv
hdl/cmd_dispatch.sv
hdl/cmd_write_pixel.sv
hdl/cmd_read_pixel.sv
hdl/framebuffer_ram.sv
hdl/fb_cmd_top.sv
verif/fb_cmd_checker.sv
verif/tb_fb_cmd.sv

// File: Makefile
# Verilator build and run for the framebuffer command front end.

VERILATOR  ?= verilator
TOP        ?= tb_fb_cmd
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation reported failure, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
